//--- rtl/lsu_pkg.sv
package lsu_pkg;

    ////////////////////////////////////////////////////////////
    // matrix unit and oram geometry
    ////////////////////////////////////////////////////////////
    localparam int MXU_ROWS    = 16;
    localparam int ROW_SEL_W   = 4;
    localparam int LANES       = 16;
    localparam int LANE_W      = 16;
    localparam int WORD_W      = 128;
    localparam int WORD_LANES  = 8;
    localparam int BEAT_W      = 64;
    localparam int ORAM_DEPTH  = 256;
    localparam int ORAM_ADDR_W = 8;

    // instruction field widths
    localparam int SRAM_ADDR_W = 12;
    localparam int DRAM_ADDR_W = 10;
    localparam int NUM_W       = 8;
    localparam int SIZE_W      = 3;
    localparam int AXI_ID_W    = 8;

    // axi write address encodings
    localparam logic [2:0] AXI_SIZE_8B    = 3'd3;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // dram store sequencer states
    localparam int         DS_STATE_W = 3;
    localparam logic [2:0] DS_IDLE    = 3'd0;
    localparam logic [2:0] DS_ADDR    = 3'd1;
    localparam logic [2:0] DS_FETCH   = 3'd2;
    localparam logic [2:0] DS_BEAT_LO = 3'd3;
    localparam logic [2:0] DS_BEAT_HI = 3'd4;
    localparam logic [2:0] DS_RESP    = 3'd5;

    // one int16 accumulator row, seen as lanes or as two oram words
    typedef union packed {
        logic [LANES-1:0][LANE_W-1:0] lane;
        logic [1:0][WORD_W-1:0]       half;
    } acc_row_t;

endpackage

//--- rtl/oram_bank.sv
`timescale 1ns/1ps

module oram_bank (
    input  logic                            clk,
    input  logic                            wr_en,
    input  logic [lsu_pkg::ORAM_ADDR_W-1:0] wr_addr,
    input  logic [lsu_pkg::WORD_W-1:0]      wr_data,
    input  logic                            rd_en,
    input  logic [lsu_pkg::ORAM_ADDR_W-1:0] rd_addr,
    output logic [lsu_pkg::WORD_W-1:0]      rd_data
);

    logic [lsu_pkg::WORD_W-1:0] mem [lsu_pkg::ORAM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, holds until the next rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- rtl/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         idu_vld,
    input  logic                         idu_st_oram,
    input  logic                         idu_st_dram,
    input  logic                         oram_store_done,
    input  logic                         dram_store_done,
    output logic                         idu_rdy,
    output logic                         st_oram_start,
    output logic                         st_dram_start,
    output logic [lsu_pkg::AXI_ID_W-1:0] burst_id
);

    logic busy;
    logic accept;

    assign idu_rdy = ~busy;

    // exactly one opcode level, and only while idle
    assign accept        = idu_vld & idu_rdy & (idu_st_oram ^ idu_st_dram);
    assign st_oram_start = accept & idu_st_oram;
    assign st_dram_start = accept & idu_st_dram;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            burst_id <= '0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
            end else if (oram_store_done | dram_store_done) begin
                busy <= 1'b0;
            end
            // engine samples the old id on the same edge
            if (st_dram_start) begin
                burst_id <= burst_id + 1'b1;
            end
        end
    end

endmodule

//--- rtl/mxu_store_engine.sv
`timescale 1ns/1ps

module mxu_store_engine (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      start,
    input  lsu_pkg::acc_row_t [lsu_pkg::MXU_ROWS-1:0] mxu_rows,
    input  logic [lsu_pkg::ROW_SEL_W-1:0]             start_y,
    input  logic [lsu_pkg::NUM_W-1:0]                 num,
    input  logic [lsu_pkg::ROW_SEL_W-1:0]             start_x,
    input  logic [lsu_pkg::SIZE_W-1:0]                size,
    input  logic                                      st_low,
    input  logic [lsu_pkg::SRAM_ADDR_W-1:0]           ld_st_addr,
    output logic                                      wr_en,
    output logic [lsu_pkg::ORAM_ADDR_W-1:0]           wr_addr,
    output logic [lsu_pkg::WORD_W-1:0]                wr_data,
    output logic                                      done
);

    logic                                                  active;
    logic [lsu_pkg::NUM_W-1:0]                             rows_left;
    logic [lsu_pkg::ROW_SEL_W-1:0]                         row_q;
    logic [lsu_pkg::ORAM_ADDR_W-1:0]                       addr_q;
    logic [lsu_pkg::ROW_SEL_W-1:0]                         start_x_q;
    logic [lsu_pkg::SIZE_W-1:0]                            size_q;
    logic                                                  st_low_q;
    lsu_pkg::acc_row_t                                     row;
    lsu_pkg::acc_row_t                                     half_row;
    logic [(1 << lsu_pkg::SIZE_W)-1:0]                     win_len;
    logic [lsu_pkg::WORD_LANES-1:0][lsu_pkg::LANE_W-1:0]   win;

    ////////////////////////////////////////////////////////////
    // row sequencing, one row per cycle
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            rows_left <= '0;
        end else if (start) begin
            active    <= 1'b1;
            // zero rows still stores one
            rows_left <= (num == '0) ? lsu_pkg::NUM_W'(1) : num;
        end else if (active) begin
            rows_left <= rows_left - 1'b1;
            if (rows_left == lsu_pkg::NUM_W'(1)) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            row_q     <= start_y;
            addr_q    <= ld_st_addr[lsu_pkg::SRAM_ADDR_W-1 -: lsu_pkg::ORAM_ADDR_W];
            start_x_q <= start_x;
            size_q    <= size;
            st_low_q  <= st_low;
        end else if (active) begin
            // row index wraps at 16
            row_q  <= row_q + 1'b1;
            addr_q <= addr_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // half select and column window
    ////////////////////////////////////////////////////////////
    assign row = mxu_rows[row_q];

    // chosen half in the low word, upper lanes read as zero
    always_comb begin
        half_row         = '0;
        half_row.half[0] = st_low_q ? row.half[0] : row.half[1];
    end

    assign win_len = (1 << lsu_pkg::SIZE_W)'(1) << size_q;

    always_comb begin
        logic [lsu_pkg::ROW_SEL_W:0] src;
        win = '0;
        for (int j = 0; j < lsu_pkg::WORD_LANES; j++) begin
            src = {1'b0, start_x_q} + (lsu_pkg::ROW_SEL_W+1)'(j);
            if (j < win_len && src < lsu_pkg::LANES) begin
                win[j] = half_row.lane[src[lsu_pkg::ROW_SEL_W-1:0]];
            end
        end
    end

    assign wr_en   = active;
    assign wr_addr = addr_q;
    assign wr_data = win;
    assign done    = active & (rows_left == lsu_pkg::NUM_W'(1));

endmodule

//--- rtl/dram_store_engine.sv
`timescale 1ns/1ps

module dram_store_engine (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic [lsu_pkg::AXI_ID_W-1:0]    burst_id,
    input  logic [lsu_pkg::DRAM_ADDR_W-1:0] dram_addr,
    input  logic [lsu_pkg::NUM_W-1:0]       num,
    input  logic [lsu_pkg::SRAM_ADDR_W-1:0] ld_st_addr,
    input  logic                            awrdy,
    input  logic                            wrdy,
    input  logic                            bvld,
    input  logic [lsu_pkg::WORD_W-1:0]      rd_data,
    output logic                            awvld,
    output logic [lsu_pkg::AXI_ID_W-1:0]    awid,
    output logic [lsu_pkg::DRAM_ADDR_W-1:0] awaddr,
    output logic [lsu_pkg::NUM_W-1:0]       awlen,
    output logic                            rd_en,
    output logic [lsu_pkg::ORAM_ADDR_W-1:0] rd_addr,
    output logic                            wvld,
    output logic [lsu_pkg::BEAT_W-1:0]      wdata,
    output logic                            wlast,
    output logic                            brdy,
    output logic                            done
);

    logic [lsu_pkg::DS_STATE_W-1:0]    state;
    logic                              rd_pend;
    logic [lsu_pkg::NUM_W-1:0]         num_eff;
    logic [lsu_pkg::NUM_W-1:0]         words_left;
    logic [lsu_pkg::ORAM_ADDR_W-1:0]   word_addr;
    logic [1:0][lsu_pkg::BEAT_W-1:0]   hold;
    logic                              last_word;

    assign num_eff   = (num == '0) ? lsu_pkg::NUM_W'(1) : num;
    assign last_word = (words_left == lsu_pkg::NUM_W'(1));

    ////////////////////////////////////////////////////////////
    // address, fetch, two beats per word, response
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= lsu_pkg::DS_IDLE;
            rd_pend <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::DS_IDLE: begin
                    if (start) state <= lsu_pkg::DS_ADDR;
                end
                lsu_pkg::DS_ADDR: begin
                    if (awrdy) state <= lsu_pkg::DS_FETCH;
                end
                lsu_pkg::DS_FETCH: begin
                    // read issued, then capture on the next cycle
                    rd_pend <= ~rd_pend;
                    if (rd_pend) state <= lsu_pkg::DS_BEAT_LO;
                end
                lsu_pkg::DS_BEAT_LO: begin
                    if (wrdy) state <= lsu_pkg::DS_BEAT_HI;
                end
                lsu_pkg::DS_BEAT_HI: begin
                    if (wrdy) state <= last_word ? lsu_pkg::DS_RESP : lsu_pkg::DS_FETCH;
                end
                lsu_pkg::DS_RESP: begin
                    if (bvld) state <= lsu_pkg::DS_IDLE;
                end
                default: state <= lsu_pkg::DS_IDLE;
            endcase
        end
    end

    // request fields and word bookkeeping
    always_ff @(posedge clk) begin
        if (start) begin
            awid       <= burst_id;
            awaddr     <= dram_addr;
            awlen      <= lsu_pkg::NUM_W'({num_eff, 1'b0} - 1'b1);
            words_left <= num_eff;
            word_addr  <= ld_st_addr[lsu_pkg::SRAM_ADDR_W-1 -: lsu_pkg::ORAM_ADDR_W];
        end
        if (state == lsu_pkg::DS_FETCH && rd_pend) begin
            hold <= rd_data;
        end
        if (state == lsu_pkg::DS_BEAT_HI && wrdy) begin
            words_left <= words_left - 1'b1;
            word_addr  <= word_addr + 1'b1;
        end
    end

    assign awvld   = (state == lsu_pkg::DS_ADDR);
    assign rd_en   = (state == lsu_pkg::DS_FETCH) & ~rd_pend;
    assign rd_addr = word_addr;

    // low half goes first
    assign wvld  = (state == lsu_pkg::DS_BEAT_LO) | (state == lsu_pkg::DS_BEAT_HI);
    assign wdata = hold[state == lsu_pkg::DS_BEAT_HI];
    assign wlast = (state == lsu_pkg::DS_BEAT_HI) & last_word;

    assign brdy = (state == lsu_pkg::DS_RESP);
    assign done = (state == lsu_pkg::DS_RESP) & bvld;

endmodule

//--- rtl/lsu.sv
`timescale 1ns/1ps

module lsu (
    input  logic                                      clk,
    input  logic                                      rst,

    // decode unit
    input  logic                                      idu_vld,
    input  logic                                      idu_st_oram,
    input  logic                                      idu_st_dram,
    input  logic [lsu_pkg::DRAM_ADDR_W-1:0]           idu_dram_addr,
    input  logic [lsu_pkg::NUM_W-1:0]                 idu_num,
    input  logic [lsu_pkg::SIZE_W-1:0]                idu_size,
    input  logic [lsu_pkg::ROW_SEL_W-1:0]             idu_start_x,
    input  logic [lsu_pkg::ROW_SEL_W-1:0]             idu_start_y,
    input  logic [lsu_pkg::SRAM_ADDR_W-1:0]           idu_ld_st_addr,
    input  logic                                      idu_st_low,
    output logic                                      idu_rdy,

    // matrix unit result rows
    input  lsu_pkg::acc_row_t [lsu_pkg::MXU_ROWS-1:0] mxu_rows,

    // axi write
    input  logic                                      awrdy,
    input  logic                                      wrdy,
    input  logic                                      bvld,
    input  logic [1:0]                                bresp,
    output logic                                      awvld,
    output logic [lsu_pkg::AXI_ID_W-1:0]              awid,
    output logic [lsu_pkg::DRAM_ADDR_W-1:0]           awaddr,
    output logic [lsu_pkg::NUM_W-1:0]                 awlen,
    output logic [2:0]                                awsize,
    output logic [1:0]                                awburst,
    output logic                                      wvld,
    output logic [lsu_pkg::BEAT_W-1:0]                wdata,
    output logic [lsu_pkg::BEAT_W/8-1:0]              wstrb,
    output logic                                      wlast,
    output logic                                      brdy
);

    logic                              st_oram_start;
    logic                              st_dram_start;
    logic                              oram_store_done;
    logic                              dram_store_done;
    logic [lsu_pkg::AXI_ID_W-1:0]      burst_id;

    // oram ports
    logic                              oram_wr_en;
    logic [lsu_pkg::ORAM_ADDR_W-1:0]   oram_wr_addr;
    logic [lsu_pkg::WORD_W-1:0]        oram_wr_data;
    logic                              oram_rd_en;
    logic [lsu_pkg::ORAM_ADDR_W-1:0]   oram_rd_addr;
    logic [lsu_pkg::WORD_W-1:0]        oram_rd_data;

    // full 8-byte beats, incrementing bursts only
    assign awsize  = lsu_pkg::AXI_SIZE_8B;
    assign awburst = lsu_pkg::AXI_BURST_INCR;
    assign wstrb   = '1;

    lsu_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .idu_vld         (idu_vld),
        .idu_st_oram     (idu_st_oram),
        .idu_st_dram     (idu_st_dram),
        .oram_store_done (oram_store_done),
        .dram_store_done (dram_store_done),
        .idu_rdy         (idu_rdy),
        .st_oram_start   (st_oram_start),
        .st_dram_start   (st_dram_start),
        .burst_id        (burst_id)
    );

    mxu_store_engine u_mxu_store (
        .clk        (clk),
        .rst        (rst),
        .start      (st_oram_start),
        .mxu_rows   (mxu_rows),
        .start_y    (idu_start_y),
        .num        (idu_num),
        .start_x    (idu_start_x),
        .size       (idu_size),
        .st_low     (idu_st_low),
        .ld_st_addr (idu_ld_st_addr),
        .wr_en      (oram_wr_en),
        .wr_addr    (oram_wr_addr),
        .wr_data    (oram_wr_data),
        .done       (oram_store_done)
    );

    oram_bank u_oram (
        .clk     (clk),
        .wr_en   (oram_wr_en),
        .wr_addr (oram_wr_addr),
        .wr_data (oram_wr_data),
        .rd_en   (oram_rd_en),
        .rd_addr (oram_rd_addr),
        .rd_data (oram_rd_data)
    );

    dram_store_engine u_dram_store (
        .clk        (clk),
        .rst        (rst),
        .start      (st_dram_start),
        .burst_id   (burst_id),
        .dram_addr  (idu_dram_addr),
        .num        (idu_num),
        .ld_st_addr (idu_ld_st_addr),
        .awrdy      (awrdy),
        .wrdy       (wrdy),
        .bvld       (bvld),
        .rd_data    (oram_rd_data),
        .awvld      (awvld),
        .awid       (awid),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .rd_en      (oram_rd_en),
        .rd_addr    (oram_rd_addr),
        .wvld       (wvld),
        .wdata      (wdata),
        .wlast      (wlast),
        .brdy       (brdy),
        .done       (dram_store_done)
    );

endmodule

//--- tests/lsu_chk.sv
`timescale 1ns/1ps

module lsu_chk (
    input logic                            clk,
    input logic                            rst,
    input logic                            idu_vld,
    input logic                            idu_rdy,
    input logic                            idu_st_oram,
    input logic                            idu_st_dram,
    input logic                            oram_store_done,
    input logic                            dram_store_done,
    input logic                            awvld,
    input logic                            awrdy,
    input logic [lsu_pkg::AXI_ID_W-1:0]    awid,
    input logic [lsu_pkg::DRAM_ADDR_W-1:0] awaddr,
    input logic [lsu_pkg::NUM_W-1:0]       awlen,
    input logic                            wvld,
    input logic                            wrdy,
    input logic                            wlast,
    input logic [lsu_pkg::BEAT_W-1:0]      wdata
);

    int   fail_count = 0;
    logic accept;
    logic done;

    assign accept = idu_vld & idu_rdy & (idu_st_oram ^ idu_st_dram);
    assign done   = oram_store_done | dram_store_done;

    // valid and payload hold until ready
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvld && !awrdy |=> awvld && $stable(awaddr) && $stable(awlen) && $stable(awid))
        else begin
            $error("awvld dropped or address payload moved before awrdy");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvld && !wrdy |=> wvld && $stable(wdata) && $stable(wlast))
        else begin
            $error("wvld dropped or beat payload moved before wrdy");
            fail_count++;
        end

    wlast_in_beat: assert property (@(posedge clk) disable iff (rst) wlast |-> wvld)
        else begin
            $error("wlast high outside a write beat");
            fail_count++;
        end

    // busy from the cycle after accept until the done pulse
    rdy_after_accept: assert property (@(posedge clk) disable iff (rst) accept |=> !idu_rdy)
        else begin
            $error("idu_rdy high right after an accept");
            fail_count++;
        end

    rdy_until_done: assert property (@(posedge clk) disable iff (rst)
        !idu_rdy && !done |=> !idu_rdy)
        else begin
            $error("idu_rdy returned without a done pulse");
            fail_count++;
        end

endmodule

bind lsu lsu_chk u_chk (
    .clk             (clk),
    .rst             (rst),
    .idu_vld         (idu_vld),
    .idu_rdy         (idu_rdy),
    .idu_st_oram     (idu_st_oram),
    .idu_st_dram     (idu_st_dram),
    .oram_store_done (oram_store_done),
    .dram_store_done (dram_store_done),
    .awvld           (awvld),
    .awrdy           (awrdy),
    .awid            (awid),
    .awaddr          (awaddr),
    .awlen           (awlen),
    .wvld            (wvld),
    .wrdy            (wrdy),
    .wlast           (wlast),
    .wdata           (wdata)
);

//--- tests/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

    localparam int N_RAND = 8;
    // rows take n+2 cycles and dram stores 8n+12 under back-pressure
    localparam int EXP_CYCLES = 5 + (3 + 2) + 2 * (8 + 2) + (8 * 16 + 12)
                              + N_RAND * ((4 + 2) + (8 * 4 + 12))
                              + (8 * 16 + 12) + (8 * 5 + 12) + (8 * 1 + 12)
                              + 3 + (8 * 4 + 12) + (8 * 2 + 12) + 4;
    localparam int CYCLE_LIMIT = 4 * EXP_CYCLES;

    logic                                                clk = 1'b0;
    logic                                                rst;
    logic                                                idu_vld, idu_st_oram, idu_st_dram;
    logic                                                idu_st_low, idu_rdy;
    logic [lsu_pkg::DRAM_ADDR_W-1:0]                     idu_dram_addr;
    logic [lsu_pkg::NUM_W-1:0]                           idu_num;
    logic [lsu_pkg::SIZE_W-1:0]                          idu_size;
    logic [lsu_pkg::ROW_SEL_W-1:0]                       idu_start_x, idu_start_y;
    logic [lsu_pkg::SRAM_ADDR_W-1:0]                     idu_ld_st_addr;
    logic [lsu_pkg::MXU_ROWS-1:0][2*lsu_pkg::WORD_W-1:0] mxu_rows;
    logic                                                awrdy = 1'b0;
    logic                                                wrdy = 1'b0;
    logic                                                bvld = 1'b0;
    logic [1:0]                                          bresp = 2'b00;
    logic                                                awvld, wvld, wlast, brdy;
    logic [lsu_pkg::AXI_ID_W-1:0]                        awid;
    logic [lsu_pkg::DRAM_ADDR_W-1:0]                     awaddr;
    logic [lsu_pkg::NUM_W-1:0]                           awlen;
    logic [2:0]                                          awsize;
    logic [1:0]                                          awburst;
    logic [lsu_pkg::BEAT_W-1:0]                          wdata;
    logic [lsu_pkg::BEAT_W/8-1:0]                        wstrb;

    // shadow oram and the beats still owed by the current burst
    logic [lsu_pkg::WORD_W-1:0]      shadow [lsu_pkg::ORAM_DEPTH];
    logic [lsu_pkg::BEAT_W-1:0]      beat_q [$];
    logic [lsu_pkg::DRAM_ADDR_W-1:0] exp_awaddr;
    logic [lsu_pkg::NUM_W-1:0]       exp_awlen;
    integer seed = 32'hc2ecf0d1;
    int   errors = 0;
    int   checks = 0;
    int   tests = 0;
    int   errors_before = 0;
    int   cycles = 0;
    int   aw_count = 0;
    int   b_count = 0;
    int   next_id = 0;
    logic bp = 1'b0;

    lsu dut (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("Fail %s got %h exp %h", name, got, exp);
        errors++;
    endtask

    task automatic report_test(input string name);
        $display("%-16s %0d errors", name, errors - errors_before);
        errors_before = errors;
        tests++;
    endtask

    task automatic randomize_rows();
        for (int r = 0; r < lsu_pkg::MXU_ROWS; r++) begin
            for (int w = 0; w < 8; w++) begin
                mxu_rows[r][w*32 +: 32] = $random(seed);
            end
        end
    endtask

    // lanes x to x+2^size-1 of the chosen half moved down to lane 0 and the rest zeroed
    function automatic logic [127:0] window_word(input logic [255:0] r, input logic low,
                                                 input logic [3:0] x, input logic [2:0] size);
        logic [127:0] h;
        logic [127:0] w;
        int           src;
        h = low ? r[127:0] : r[255:128];
        w = '0;
        for (int j = 0; j < 8; j++) begin
            src = x + j;
            if (j < (1 << size) && src < 8) begin
                w[j*16 +: 16] = h[src*16 +: 16];
            end
        end
        return w;
    endfunction

    task automatic row_store(input logic [7:0] waddr, input logic [3:0] y,
                             input logic [7:0] num, input logic [3:0] x,
                             input logic [2:0] size, input logic low);
        int n;
        int wait_cycles;
        n = (num == 0) ? 1 : num;
        for (int k = 0; k < n; k++) begin
            shadow[waddr + 8'(k)] = window_word(mxu_rows[4'(y + k)], low, x, size);
        end
        idu_start_y    = y;
        idu_num        = num;
        idu_start_x    = x;
        idu_size       = size;
        idu_st_low     = low;
        idu_ld_st_addr = {waddr, 4'($random(seed))};
        idu_st_oram    = 1'b1;
        idu_vld        = 1'b1;
        next_cycle();
        idu_vld     = 1'b0;
        idu_st_oram = 1'b0;
        wait_cycles = 1;
        while (!idu_rdy) begin
            next_cycle();
            wait_cycles++;
        end
        checks++;
        assert (wait_cycles == n + 1)
            else report_mismatch("idu_rdy return cycle", wait_cycles, n + 1);
    endtask

    // stray raises idu_vld again while the store is busy
    task automatic dram_store(input logic [7:0] waddr, input logic [7:0] num,
                              input logic stray);
        int n;
        int aw_before;
        int b_before;
        n = (num == 0) ? 1 : num;
        for (int k = 0; k < n; k++) begin
            beat_q.push_back(shadow[waddr + 8'(k)][63:0]);
            beat_q.push_back(shadow[waddr + 8'(k)][127:64]);
        end
        exp_awaddr     = 10'($random(seed));
        exp_awlen      = 8'(2 * n - 1);
        aw_before      = aw_count;
        b_before       = b_count;
        idu_dram_addr  = exp_awaddr;
        idu_num        = num;
        idu_ld_st_addr = {waddr, 4'($random(seed))};
        idu_st_dram    = 1'b1;
        idu_vld        = 1'b1;
        next_cycle();
        idu_vld = stray;
        next_cycle();
        idu_vld     = 1'b0;
        idu_st_dram = 1'b0;
        while (!idu_rdy) begin
            next_cycle();
        end
        next_id++;
        checks += 2;
        assert (aw_count == aw_before + 1) else begin
            $display("expected one address request per dram store, saw %0d",
                     aw_count - aw_before);
            errors++;
        end
        assert (b_count == b_before + 1 && beat_q.size() == 0) else begin
            $display("dram store ended without its response or with beats missing");
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // AXI slave side and bus monitor
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        #1;
        awrdy = bp ? 1'($random(seed)) : 1'b1;
        wrdy  = bp ? 1'($random(seed)) : 1'b1;
        bvld  = brdy & (bp ? 1'($random(seed)) : 1'b1);
        bresp = 2'($random(seed));
    end

    always @(posedge clk) begin
        if (!rst && awvld && awrdy) begin
            aw_count++;
            checks++;
            assert (awaddr === exp_awaddr) else report_mismatch("awaddr", awaddr, exp_awaddr);
            assert (awlen === exp_awlen) else report_mismatch("awlen", awlen, exp_awlen);
            assert (awid === 8'(next_id)) else report_mismatch("awid", awid, 8'(next_id));
            assert (awsize === 3'd3) else report_mismatch("awsize", awsize, 3'd3);
            assert (awburst === 2'b01) else report_mismatch("awburst", awburst, 2'b01);
        end
        if (!rst && wvld && wrdy) begin
            checks++;
            if (beat_q.size() == 0) begin
                $display("write beat arrived when none was expected");
                errors++;
            end else begin
                assert (wdata === beat_q[0]) else report_mismatch("wdata", wdata, beat_q[0]);
                assert (wlast === (beat_q.size() == 1))
                    else report_mismatch("wlast", wlast, beat_q.size() == 1);
                assert (wstrb === 8'hff) else report_mismatch("wstrb", wstrb, 8'hff);
                void'(beat_q.pop_front());
            end
        end
        if (!rst && bvld && brdy) begin
            b_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, run still busy after %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [7:0] waddr;
        logic [7:0] num;
        rst            = 1'b1;
        idu_vld        = 1'b0;
        idu_st_oram    = 1'b0;
        idu_st_dram    = 1'b0;
        idu_st_low     = 1'b0;
        idu_dram_addr  = '0;
        idu_num        = '0;
        idu_size       = '0;
        idu_start_x    = '0;
        idu_start_y    = '0;
        idu_ld_st_addr = '0;
        mxu_rows       = '0;
        repeat (4) next_cycle();
        rst = 1'b0;
        next_cycle();

        // idle outputs, then row latency with wraparound
        checks++;
        assert (idu_rdy && !awvld && !wvld && !brdy) else begin
            $display("outputs not idle after reset");
            errors++;
        end
        randomize_rows();
        row_store(8'h00, 4'd14, 8'd3, 4'd0, 3'd3, 1'b1);
        report_test("reset_idle");

        // full window with low halves then high halves
        randomize_rows();
        row_store(8'h10, 4'd4, 8'd8, 4'd0, 3'd3, 1'b1);
        row_store(8'h18, 4'd4, 8'd8, 4'd0, 3'd3, 1'b0);
        dram_store(8'h10, 8'd16, 1'b0);
        report_test("full_window");

        for (int i = 0; i < N_RAND; i++) begin
            randomize_rows();
            waddr = 8'($random(seed));
            num   = 8'(1 + ($random(seed) & 3));
            row_store(waddr, 4'($random(seed)), num, 4'($random(seed)),
                      3'($random(seed) & 3), 1'($random(seed)));
            dram_store(waddr, num, 1'b0);
        end
        report_test("random_window");

        // random ready stalls and a num of zero storing one word
        bp = 1'b1;
        dram_store(8'h10, 8'd16, 1'b0);
        dram_store(8'h13, 8'd5, 1'b0);
        dram_store(8'h1f, 8'd0, 1'b0);
        bp = 1'b0;
        report_test("back_pressure");

        // strobe with no opcode and a second strobe while busy
        idu_vld = 1'b1;
        repeat (3) begin
            next_cycle();
            checks++;
            assert (idu_rdy) else begin
                $display("strobe without an opcode was accepted");
                errors++;
            end
        end
        idu_vld = 1'b0;
        dram_store(8'h10, 8'd4, 1'b1);
        // the next id shows whether the busy strobe was counted
        dram_store(8'h14, 8'd2, 1'b0);
        report_test("stray_strobe");

        repeat (3) next_cycle();
        errors += dut.u_chk.fail_count;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- lsu.f
rtl/lsu_pkg.sv
rtl/oram_bank.sv
rtl/lsu_ctrl.sv
rtl/mxu_store_engine.sv
rtl/dram_store_engine.sv
rtl/lsu.sv
tests/lsu_chk.sv
tests/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - files:
      - rtl/lsu_pkg.sv
      - rtl/oram_bank.sv
      - rtl/lsu_ctrl.sv
      - rtl/mxu_store_engine.sv
      - rtl/dram_store_engine.sv
      - rtl/lsu.sv
  - target: test
    files:
      - tests/lsu_chk.sv
      - tests/lsu_tb.sv
